// File: src/hsdPkg.sv
package hsdPkg;

////////////////////////////////////////////////////////////////////////////
// Widths

// Stored sample width, ADC data is sign-extended into it
localparam int SAMPLE_WIDTH = 16;
localparam int ADC_WIDTH = 12;

// External event trigger lines
localparam int TRIGGER_WIDTH = 6;

// Host register data width
localparam int CSR_WIDTH = 32;

////////////////////////////////////////////////////////////////////////////
// Types

typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

// Host register indices
typedef enum logic [3:0] {
    CSR_ACQ_CONTROL  = 4'd0,
    CSR_TRIGGER_MASK = 4'd1,
    CSR_SOFT_TRIGGER = 4'd2,
    CSR_RANGE        = 4'd3,
    CSR_MICROSECONDS = 4'd4,
    CSR_SECONDS      = 4'd5,
    CSR_INTERLOCK    = 4'd6
} csrIdx_e;

// Capture FSM states
typedef enum logic [2:0] {
    ACQ_IDLE    = 3'd0,
    ACQ_FILLING = 3'd1,
    ACQ_ARMED   = 3'd2,
    ACQ_POST    = 3'd3,
    ACQ_READOUT = 3'd4
} acqState_e;

typedef struct packed {
    logic                 strobe;
    csrIdx_e              index;
    logic [CSR_WIDTH-1:0] data;
} csrWrite_t;

// One word of the record readout stream
typedef struct packed {
    logic    valid;
    logic    last;
    sample_t sample;
} readWord_t;

typedef struct packed {
    logic       arm;
    logic [7:0] pretrigger;
} acqConfig_t;

typedef struct packed {
    sample_t max;
    sample_t min;
} rangeStatus_t;

endpackage

// File: src/bootTimer.sv
`timescale 1ns/1ps

module bootTimer #(
    parameter int CLK_RATE = 100000000
) (
    input  logic                         sysClk,
    input  logic                         rst,
    output logic [hsdPkg::CSR_WIDTH-1:0] microseconds,
    output logic [hsdPkg::CSR_WIDTH-1:0] seconds
);

    import hsdPkg::*;

    localparam int TICKS_PER_US = CLK_RATE / 1000000;
    localparam int PRESCALE_WIDTH = (TICKS_PER_US > 1) ? $clog2(TICKS_PER_US) : 1;
    localparam logic [PRESCALE_WIDTH-1:0] PRESCALE_LAST = PRESCALE_WIDTH'(TICKS_PER_US - 1);
    localparam logic [19:0] US_LAST = 20'd999999;

    logic [PRESCALE_WIDTH-1:0] prescale;
    logic [19:0]               usInSecond;
    logic                      usTick;

    assign usTick = (prescale == PRESCALE_LAST);

    always_ff @(posedge sysClk) begin
        if (rst) begin
            prescale <= '0;
            usInSecond <= '0;
            microseconds <= '0;
            seconds <= '0;
        end
        else begin
            prescale <= usTick ? '0 : prescale + 1'b1;
            if (usTick) begin
                microseconds <= microseconds + 1'b1;
                // Seconds advance on every millionth microsecond
                if (usInSecond == US_LAST) begin
                    usInSecond <= '0;
                    seconds <= seconds + 1'b1;
                end
                else begin
                    usInSecond <= usInSecond + 1'b1;
                end
            end
        end
    end

    // Clock must be a whole number of MHz
    assert property (@(posedge sysClk) (TICKS_PER_US > 0) && (CLK_RATE % 1000000 == 0))
        else $error("bootTimer: CLK_RATE %0d is not a multiple of 1 MHz", CLK_RATE);

endmodule

// File: src/csrBank.sv
`timescale 1ns/1ps

module csrBank (
    input  logic                             sysClk,
    input  logic                             rst,
    input  hsdPkg::csrWrite_t                csrWr,
    input  hsdPkg::csrIdx_e                  readIndex,
    input  hsdPkg::acqState_e                acqState,
    input  hsdPkg::rangeStatus_t             rangeStatus,
    input  logic [hsdPkg::CSR_WIDTH-1:0]     microseconds,
    input  logic [hsdPkg::CSR_WIDTH-1:0]     seconds,
    input  logic                             resetButton,
    output logic [hsdPkg::CSR_WIDTH-1:0]     readData,
    output hsdPkg::acqConfig_t               acqConfig,
    output logic [hsdPkg::TRIGGER_WIDTH-1:0] triggerMask,
    output logic                             softTrigger,
    output logic                             rangeClear,
    output logic                             relayControl
);

    import hsdPkg::*;

    logic [7:0] pretrigger;
    logic       controlWrite;

    ////////////////////////////////////////////////////////////////////////////
    // Write decoding

    assign controlWrite = csrWr.strobe && (csrWr.index == CSR_ACQ_CONTROL);

    // Pulses act at the same edge as the write strobe
    assign acqConfig.arm = controlWrite && csrWr.data[0];
    assign acqConfig.pretrigger = csrWr.data[15:8];
    assign softTrigger = csrWr.strobe && (csrWr.index == CSR_SOFT_TRIGGER);
    assign rangeClear = csrWr.strobe && (csrWr.index == CSR_RANGE);

    // Stored configuration
    always_ff @(posedge sysClk) begin
        if (rst) begin
            pretrigger <= '0;
            triggerMask <= '0;
            relayControl <= 1'b0;
        end
        else if (csrWr.strobe) begin
            case (csrWr.index)
                CSR_ACQ_CONTROL: begin
                    pretrigger <= csrWr.data[15:8];
                end
                CSR_TRIGGER_MASK: begin
                    triggerMask <= csrWr.data[TRIGGER_WIDTH-1:0];
                end
                CSR_INTERLOCK: begin
                    relayControl <= csrWr.data[0];
                end
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read multiplexer

    // One cycle of latency from readIndex to readData
    always_ff @(posedge sysClk) begin
        case (readIndex)
            CSR_ACQ_CONTROL: begin
                readData <= CSR_WIDTH'({pretrigger, 5'b0, acqState});
            end
            CSR_TRIGGER_MASK: begin
                readData <= CSR_WIDTH'(triggerMask);
            end
            CSR_RANGE: begin
                // Max in upper half, min in lower half
                readData <= CSR_WIDTH'(rangeStatus);
            end
            CSR_MICROSECONDS: begin
                readData <= microseconds;
            end
            CSR_SECONDS: begin
                readData <= seconds;
            end
            CSR_INTERLOCK: begin
                readData <= CSR_WIDTH'({relayControl, resetButton});
            end
            default: begin
                readData <= '0;
            end
        endcase
    end

endmodule

// File: src/triggerCondition.sv
`timescale 1ns/1ps

module triggerCondition (
    input  logic                             sysClk,
    input  logic                             rst,
    input  logic [hsdPkg::TRIGGER_WIDTH-1:0] eventTriggers,
    input  logic [hsdPkg::TRIGGER_WIDTH-1:0] triggerMask,
    input  logic                             softTrigger,
    output logic                             acqTrigger
);

    import hsdPkg::*;

    // Two-flop synchroniser, then one delay stage for the edge detector
    logic [TRIGGER_WIDTH-1:0] syncMeta;
    logic [TRIGGER_WIDTH-1:0] syncStable;
    logic [TRIGGER_WIDTH-1:0] syncDelayed;
    logic [TRIGGER_WIDTH-1:0] risingEdges;
    logic                     eventHit;

    assign risingEdges = syncStable & ~syncDelayed;
    assign eventHit = |(risingEdges & triggerMask);

    always_ff @(posedge sysClk) begin
        if (rst) begin
            syncMeta <= '0;
            syncStable <= '0;
            syncDelayed <= '0;
            acqTrigger <= 1'b0;
        end
        else begin
            syncMeta <= eventTriggers;
            syncStable <= syncMeta;
            syncDelayed <= syncStable;
            // Mask gates event edges only, software trigger merges after it
            acqTrigger <= eventHit || softTrigger;
        end
    end

endmodule

// File: src/rangeCheck.sv
`timescale 1ns/1ps

module rangeCheck (
    input  logic                 sysClk,
    input  logic                 rst,
    input  hsdPkg::sample_t      adcSample,
    input  logic                 rangeClear,
    output hsdPkg::rangeStatus_t rangeStatus
);

    import hsdPkg::*;

    // Extremes of the sign-extended ADC code
    localparam sample_t SAMPLE_HIGH = sample_t'((1 << (ADC_WIDTH - 1)) - 1);
    localparam sample_t SAMPLE_LOW = sample_t'(-(1 << (ADC_WIDTH - 1)));

    sample_t minSample;
    sample_t maxSample;
    logic    seen;

    always_ff @(posedge sysClk) begin
        if (rst || rangeClear) begin
            // Inverted extremes so the next sample sets both
            minSample <= SAMPLE_HIGH;
            maxSample <= SAMPLE_LOW;
            seen <= 1'b0;
        end
        else begin
            if (adcSample < minSample) begin
                minSample <= adcSample;
            end
            if (adcSample > maxSample) begin
                maxSample <= adcSample;
            end
            seen <= 1'b1;
        end
    end

    assign rangeStatus.max = maxSample;
    assign rangeStatus.min = minSample;

    // Once any sample has landed the window is never inverted
    assert property (@(posedge sysClk) disable iff (rst)
        seen |-> (minSample <= maxSample))
        else $error("rangeCheck: min %0d above max %0d", minSample, maxSample);

endmodule

// File: src/acqCapture.sv
`timescale 1ns/1ps

module acqCapture #(
    parameter int RECORD_LENGTH = 64,
    parameter int CREDIT_COUNT = 4
) (
    input  logic               sysClk,
    input  logic               rst,
    input  hsdPkg::sample_t    adcSample,
    input  hsdPkg::acqConfig_t acqConfig,
    input  logic               acqTrigger,
    input  logic               creditReturn,
    output hsdPkg::acqState_e  acqState,
    output hsdPkg::readWord_t  readout
);

    import hsdPkg::*;

    localparam int ADDR_WIDTH = $clog2(RECORD_LENGTH);
    localparam int CREDIT_WIDTH = $clog2(CREDIT_COUNT + 1);
    localparam logic [ADDR_WIDTH:0] LAST_INDEX = (ADDR_WIDTH + 1)'(RECORD_LENGTH - 1);

    sample_t buffer [0:RECORD_LENGTH-1];

    acqState_e               state;
    logic [ADDR_WIDTH-1:0]   writeAddr;
    logic [ADDR_WIDTH-1:0]   startAddr;
    logic [ADDR_WIDTH-1:0]   readAddr;
    logic [ADDR_WIDTH-1:0]   preCount;
    // Fill count, then post-trigger countdown, then readout index
    logic [ADDR_WIDTH:0]     count;
    logic [CREDIT_WIDTH-1:0] credits;
    logic                    storing;
    logic                    emit;
    logic                    outValid;
    logic                    outLast;
    sample_t                 outSample;

    assign storing = (state == ACQ_FILLING) || (state == ACQ_ARMED) || (state == ACQ_POST);
    assign emit = (state == ACQ_READOUT) && (credits != '0) && !count[ADDR_WIDTH]
                  && !acqConfig.arm;
    assign readAddr = startAddr + count[ADDR_WIDTH-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Capture FSM and credit counter
    always_ff @(posedge sysClk) begin
        if (rst) begin
            state <= ACQ_IDLE;
            writeAddr <= '0;
            startAddr <= '0;
            preCount <= '0;
            count <= '0;
            credits <= CREDIT_WIDTH'(CREDIT_COUNT);
            outValid <= 1'b0;
            outLast <= 1'b0;
        end
        else begin
            credits <= credits - CREDIT_WIDTH'(emit) + CREDIT_WIDTH'(creditReturn);
            outValid <= emit;
            outLast <= emit && (count == LAST_INDEX);
            if (storing) begin
                writeAddr <= writeAddr + 1'b1;
            end
            if (acqConfig.arm) begin
                // Arm restarts from any state
                state <= ACQ_FILLING;
                preCount <= ADDR_WIDTH'(acqConfig.pretrigger);
                count <= '0;
            end
            else begin
                case (state)
                    ACQ_FILLING: begin
                        count <= count + 1'b1;
                        if ((count + 1'b1) >= {1'b0, preCount}) begin
                            state <= ACQ_ARMED;
                        end
                    end
                    ACQ_ARMED: begin
                        // Sample stored at this edge is element PRE
                        if (acqTrigger) begin
                            startAddr <= writeAddr - preCount;
                            if (&preCount) begin
                                state <= ACQ_READOUT;
                                count <= '0;
                            end
                            else begin
                                state <= ACQ_POST;
                                count <= {1'b0, ~preCount};
                            end
                        end
                    end
                    ACQ_POST: begin
                        if (count == 1) begin
                            state <= ACQ_READOUT;
                            count <= '0;
                        end
                        else begin
                            count <= count - 1'b1;
                        end
                    end
                    ACQ_READOUT: begin
                        if (emit) begin
                            count <= count + 1'b1;
                        end
                        if (outValid && outLast) begin
                            state <= ACQ_IDLE;
                        end
                    end
                    default: begin
                        state <= ACQ_IDLE;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Circular buffer and readout data
    always_ff @(posedge sysClk) begin
        if (storing) begin
            buffer[writeAddr] <= adcSample;
        end
        if (emit) begin
            outSample <= buffer[readAddr];
        end
    end

    assign acqState = state;
    assign readout.valid = outValid;
    assign readout.last = outLast;
    assign readout.sample = outSample;

    // Consumer returned more credits than words it received
    assert property (@(posedge sysClk) disable iff (rst) credits <= CREDIT_COUNT)
        else $error("acqCapture: credits %0d above %0d", credits, CREDIT_COUNT);

    // No word leaks out while capturing or idle
    assert property (@(posedge sysClk) disable iff (rst) outValid |-> (state == ACQ_READOUT))
        else $error("acqCapture: readout valid outside READOUT");

endmodule

// File: src/hsdTop.sv
`timescale 1ns/1ps

module hsdTop #(
    parameter int CLK_RATE = 100000000,
    parameter int RECORD_LENGTH = 64,
    parameter int CREDIT_COUNT = 4
) (
    input  logic                             sysClk,
    input  logic                             rst,
    input  hsdPkg::csrWrite_t                csrWr,
    input  hsdPkg::csrIdx_e                  readIndex,
    output logic [hsdPkg::CSR_WIDTH-1:0]     readData,
    input  hsdPkg::sample_t                  adcSample,
    input  logic [hsdPkg::TRIGGER_WIDTH-1:0] eventTriggers,
    input  logic                             resetButton,
    output logic                             relayControl,
    output hsdPkg::readWord_t                readout,
    input  logic                             creditReturn
);

    import hsdPkg::*;

    acqConfig_t               acqConfig;
    logic [TRIGGER_WIDTH-1:0] triggerMask;
    logic                     softTrigger;
    logic                     rangeClear;
    logic                     acqTrigger;
    acqState_e                acqState;
    rangeStatus_t             rangeStatus;
    logic [CSR_WIDTH-1:0]     microseconds;
    logic [CSR_WIDTH-1:0]     seconds;

    ////////////////////////////////////////////////////////////////////////////
    // Host registers
    csrBank csrBank (
        .sysClk(sysClk),
        .rst(rst),
        .csrWr(csrWr),
        .readIndex(readIndex),
        .acqState(acqState),
        .rangeStatus(rangeStatus),
        .microseconds(microseconds),
        .seconds(seconds),
        .resetButton(resetButton),
        .readData(readData),
        .acqConfig(acqConfig),
        .triggerMask(triggerMask),
        .softTrigger(softTrigger),
        .rangeClear(rangeClear),
        .relayControl(relayControl));

    ////////////////////////////////////////////////////////////////////////////
    // Timekeeping
    bootTimer #(.CLK_RATE(CLK_RATE))
      bootTimer (
        .sysClk(sysClk),
        .rst(rst),
        .microseconds(microseconds),
        .seconds(seconds));

    ////////////////////////////////////////////////////////////////////////////
    // Triggers and ADC monitoring
    triggerCondition triggerCondition (
        .sysClk(sysClk),
        .rst(rst),
        .eventTriggers(eventTriggers),
        .triggerMask(triggerMask),
        .softTrigger(softTrigger),
        .acqTrigger(acqTrigger));

    rangeCheck rangeCheck (
        .sysClk(sysClk),
        .rst(rst),
        .adcSample(adcSample),
        .rangeClear(rangeClear),
        .rangeStatus(rangeStatus));

    ////////////////////////////////////////////////////////////////////////////
    // Acquisition
    acqCapture #(
        .RECORD_LENGTH(RECORD_LENGTH),
        .CREDIT_COUNT(CREDIT_COUNT))
      acqCapture (
        .sysClk(sysClk),
        .rst(rst),
        .adcSample(adcSample),
        .acqConfig(acqConfig),
        .acqTrigger(acqTrigger),
        .creditReturn(creditReturn),
        .acqState(acqState),
        .readout(readout));

endmodule

// File: verif/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Every driven ADC sample, keyed by the clock edge that captures it
sample_t sampleLog [int];

function automatic void logSample(input int edgeNum, input sample_t value);
    sampleLog[edgeNum] = value;
endfunction

function automatic sample_t loggedSample(input int edgeNum);
    if (sampleLog.exists(edgeNum)) begin
        return sampleLog[edgeNum];
    end
    return '0;
endfunction

////////////////////////////////////////////////////////////////////////////
// Expected record

// Element pre is the sample taken at the trigger edge
// Lower elements precede it, higher ones follow one per cycle
function automatic sample_t expectedElement(input int trigEdge, input int pre, input int idx);
    return loggedSample(trigEdge - pre + idx);
endfunction

////////////////////////////////////////////////////////////////////////////
// Range and timer

// Max in the upper half, min in the lower half
function automatic logic [31:0] expectedRange(input int firstEdge, input int lastEdge);
    sample_t lo;
    sample_t hi;
    int      e;
    lo = loggedSample(firstEdge);
    hi = lo;
    for (e = firstEdge + 1; e <= lastEdge; e++) begin
        if (loggedSample(e) < lo) begin
            lo = loggedSample(e);
        end
        if (loggedSample(e) > hi) begin
            hi = loggedSample(e);
        end
    end
    return {hi, lo};
endfunction

// Microseconds elapsed after a number of clocks out of reset
function automatic longint expectedMicros(input int cycles, input int ticksPerUs);
    return longint'(cycles / ticksPerUs);
endfunction

`endif

// File: verif/tbHsd.sv
`timescale 1ns/1ps

module tbHsd;

    import hsdPkg::*;

    localparam int CLK_RATE = 25000000;
    localparam int RECORD_LENGTH = 16;
    localparam int CREDIT_COUNT = 4;
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int TICKS_PER_US = CLK_RATE / 1000000;

    // Cycle budget of each test
    localparam int SOFT_CYCLES = 100;
    localparam int CREDIT_CYCLES = 100;
    localparam int MASK_CYCLES = 160;
    localparam int RANGE_CYCLES = 40;
    localparam int TIMER_CYCLES = 10;
    localparam int INTERLOCK_CYCLES = 20;
    localparam int WATCHDOG_NS = 2 * CLK_PERIOD * (RESET_CYCLES + SOFT_CYCLES
        + CREDIT_CYCLES + MASK_CYCLES + RANGE_CYCLES + TIMER_CYCLES + INTERLOCK_CYCLES);

    localparam int STATE_TIMEOUT = 40;
    localparam int RECORD_TIMEOUT = 200;

    logic                     sysClk = 1'b0;
    logic                     rst;
    csrWrite_t                csrWr;
    csrIdx_e                  readIndex;
    logic [CSR_WIDTH-1:0]     readData;
    sample_t                  adcSample;
    logic [TRIGGER_WIDTH-1:0] eventTriggers;
    logic                     resetButton;
    logic                     relayControl;
    readWord_t                readout;
    logic                     creditReturn;

    int        seed;
    int        cycle;
    int        errors;
    int        checks;
    int        testsRun;
    int        testErrorBase;
    string     curTest;
    readWord_t recWords [$];
    // Cycle at which each outstanding credit goes back
    int        creditDue [$];
    int        wordsSeen;
    int        creditsReturned;

    `include "tbModel.svh"

    hsdTop #(
        .CLK_RATE(CLK_RATE),
        .RECORD_LENGTH(RECORD_LENGTH),
        .CREDIT_COUNT(CREDIT_COUNT))
      uut (
        .sysClk(sysClk),
        .rst(rst),
        .csrWr(csrWr),
        .readIndex(readIndex),
        .readData(readData),
        .adcSample(adcSample),
        .eventTriggers(eventTriggers),
        .resetButton(resetButton),
        .relayControl(relayControl),
        .readout(readout),
        .creditReturn(creditReturn));

    always #(CLK_PERIOD / 2) sysClk = ~sysClk;

    ////////////////////////////////////////////////////////////////////////////
    // Cycle stepping and credit consumer

    // Outputs are read before the next inputs are driven
    task automatic tick();
        int raw;
        int delay;
        int i;
        @(posedge sysClk);
        #2;
        cycle++;
        csrWr.strobe = 1'b0;
        if (readout.valid) begin
            recWords.push_back(readout);
            wordsSeen++;
            delay = $random(seed) & 3;
            creditDue.push_back(cycle + delay);
            checks++;
            assert (wordsSeen - creditsReturned <= CREDIT_COUNT) else begin
                $display("ERR %s credits outstanding: expected at most %0d, actual %0d",
                         curTest, CREDIT_COUNT, wordsSeen - creditsReturned);
                errors++;
            end
        end
        // At most one credit goes back per cycle
        creditReturn = 1'b0;
        for (i = 0; i < creditDue.size(); i++) begin
            if (!creditReturn && creditDue[i] <= cycle) begin
                creditDue.delete(i);
                creditReturn = 1'b1;
                creditsReturned++;
            end
        end
        raw = $random(seed);
        adcSample = {{(SAMPLE_WIDTH - ADC_WIDTH){raw[ADC_WIDTH-1]}}, raw[ADC_WIDTH-1:0]};
        logSample(cycle + 1, adcSample);
    endtask

    task automatic writeReg(input csrIdx_e index, input logic [CSR_WIDTH-1:0] data);
        csrWr.strobe = 1'b1;
        csrWr.index = index;
        csrWr.data = data;
        tick();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks and bookkeeping

    task automatic checkEqual(input string what, input longint expected, input longint actual);
        checks++;
        assert (actual == expected) else begin
            $display("ERR %s %s: expected %0d, actual %0d", curTest, what, expected, actual);
            errors++;
        end
    endtask

    task automatic checkNear(input string what, input longint expected, input longint actual);
        checks++;
        assert ((actual >= expected - 1) && (actual <= expected + 1)) else begin
            $display("ERR %s %s: expected %0d +/- 1, actual %0d", curTest, what, expected, actual);
            errors++;
        end
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testErrorBase = errors;
        testsRun++;
    endtask

    task automatic endTest();
        if (errors == testErrorBase) begin
            $display("%s: pass", curTest);
        end
        else begin
            $display("%s: fail with %0d errors", curTest, errors - testErrorBase);
        end
    endtask

    task automatic waitForState(input acqState_e want);
        int waited;
        waited = 0;
        readIndex = CSR_ACQ_CONTROL;
        tick();
        while (readData[2:0] != want && waited < STATE_TIMEOUT) begin
            tick();
            waited++;
        end
        checks++;
        assert (readData[2:0] == want) else begin
            $display("%s: status never reached %s", curTest, want.name());
            errors++;
        end
    endtask

    task automatic armCapture(input logic [7:0] pre);
        writeReg(CSR_ACQ_CONTROL, {16'd0, pre, 7'd0, 1'b1});
        waitForState(ACQ_ARMED);
    endtask

    task automatic collectRecord();
        int waited;
        waited = 0;
        while (recWords.size() < RECORD_LENGTH && waited < RECORD_TIMEOUT) begin
            tick();
            waited++;
        end
        checks++;
        assert (recWords.size() == RECORD_LENGTH) else begin
            $display("%s: readout delivered %0d words instead of %0d",
                     curTest, recWords.size(), RECORD_LENGTH);
            errors++;
        end
        // Drain the consumer so every credit is back
        while (creditDue.size() != 0) begin
            tick();
        end
        checkEqual("words after drain", longint'(RECORD_LENGTH), longint'(recWords.size()));
    endtask

    task automatic checkRecord(input int trigEdge, input int pre);
        int i;
        for (i = 0; i < recWords.size(); i++) begin
            checkEqual($sformatf("word %0d sample", i),
                       longint'(expectedElement(trigEdge, pre, i)),
                       longint'(recWords[i].sample));
            checkEqual($sformatf("word %0d last", i),
                       longint'(i == RECORD_LENGTH - 1), longint'(recWords[i].last));
        end
    endtask

    task automatic pulseEvent(input int line, output int sampledEdge);
        eventTriggers[line] = 1'b1;
        sampledEdge = cycle + 1;
        repeat (4) tick();
        eventTriggers[line] = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests

    task automatic runCapture(input string name, input logic [7:0] pre);
        int trigEdge;
        startTest(name);
        armCapture(pre);
        recWords.delete();
        writeReg(CSR_SOFT_TRIGGER, 32'd1);
        // Write edge k raises acqTrigger, the capture acts at k+1
        trigEdge = cycle + 1;
        collectRecord();
        checkRecord(trigEdge, int'(pre));
        endTest();
    endtask

    task automatic runTriggerMask();
        int pulseEdge;
        startTest("triggerMask");
        writeReg(CSR_TRIGGER_MASK, 32'd0);
        armCapture(8'd5);
        recWords.delete();
        pulseEvent(2, pulseEdge);
        repeat (12) tick();
        checkEqual("status with line masked", longint'(ACQ_ARMED), longint'(readData[2:0]));
        checkEqual("words with line masked", longint'(0), longint'(recWords.size()));
        writeReg(CSR_TRIGGER_MASK, 32'h4);
        pulseEvent(2, pulseEdge);
        collectRecord();
        // Synchroniser, edge detector and trigger register add three edges
        checkRecord(pulseEdge + 3, 5);
        endTest();
    endtask

    task automatic runRangeMonitor();
        int clearEdge;
        startTest("rangeMonitor");
        writeReg(CSR_RANGE, 32'd0);
        clearEdge = cycle;
        repeat (20) tick();
        readIndex = CSR_RANGE;
        tick();
        // Read holds samples up to the edge before the one that took readIndex
        checkEqual("range", longint'(expectedRange(clearEdge + 1, cycle - 1)),
                   longint'(readData));
        endTest();
    endtask

    task automatic runBootTimer();
        startTest("bootTimer");
        readIndex = CSR_MICROSECONDS;
        tick();
        checkNear("microseconds", expectedMicros(cycle - RESET_CYCLES, TICKS_PER_US),
                  longint'(readData));
        endTest();
    endtask

    task automatic runInterlock();
        startTest("interlock");
        resetButton = 1'b1;
        writeReg(CSR_INTERLOCK, 32'd1);
        checkEqual("relayControl after set", longint'(1), longint'(relayControl));
        readIndex = CSR_INTERLOCK;
        tick();
        // Relay in bit 1, button in bit 0
        checkEqual("readback after set", longint'(3), longint'(readData));
        writeReg(CSR_INTERLOCK, 32'd0);
        checkEqual("relayControl after clear", longint'(0), longint'(relayControl));
        tick();
        checkEqual("readback after clear", longint'(1), longint'(readData));
        resetButton = 1'b0;
        tick();
        checkEqual("readback with button released", longint'(0), longint'(readData));
        endTest();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        seed = 86;
        cycle = 0;
        errors = 0;
        checks = 0;
        testsRun = 0;
        testErrorBase = 0;
        wordsSeen = 0;
        creditsReturned = 0;
        curTest = "reset";
        rst = 1'b1;
        csrWr = '0;
        readIndex = CSR_ACQ_CONTROL;
        adcSample = '0;
        eventTriggers = '0;
        resetButton = 1'b0;
        creditReturn = 1'b0;
        repeat (RESET_CYCLES) tick();
        rst = 1'b0;
        runCapture("softTrigger", 8'd5);
        runCapture("creditBackPressure", 8'd9);
        runTriggerMask();
        runRangeMonitor();
        runBootTimer();
        runInterlock();
        $display("Tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at cycle %0d during %s", cycle, curTest);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+verif
src/hsdPkg.sv
src/bootTimer.sv
src/csrBank.sv
src/triggerCondition.sv
src/rangeCheck.sv
src/acqCapture.sv
src/hsdTop.sv
verif/tbHsd.sv

// File: run.sh
#!/bin/sh
# Build and run the digitizer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tbHsd -o simHsd

# Pass or fail is read from the simulation output
simOut=$(./obj_dir/simHsd)
echo "$simOut"

if echo "$simOut" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
